/* common/coreTypesPkg.sv */
package coreTypesPkg;

    localparam int addrWidth     = 32; // byte address, one word wide
    localparam int dataWidth     = 32;
    localparam int regAddrWidth  = 5;
    localparam int imemDepth     = 64; // words
    localparam int imemAddrWidth = 6;

    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [2:0] f3Word   = 3'b010; // lw, sw
    localparam logic [2:0] f3Jalr   = 3'b000;

    // operand forward select
    localparam logic [1:0] fwdReg = 2'b00; // register file value
    localparam logic [1:0] fwdMem = 2'b10; // alu result in memory stage
    localparam logic [1:0] fwdWb  = 2'b01; // writeback result

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluSll = 3'b110
    } aluCtrlT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b100
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu = 2'b00,
        resMem = 2'b01,
        resPc4 = 2'b10  // link address
    } resultSrcT;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      jump;
        logic      branch;
        logic      branchNe;   // bne, inverts the zero test
        aluCtrlT   aluControl;
        logic      aluSrc;     // immediate as operand b
        logic      jalrSel;    // target from rs1 instead of pc
    } ctrlT;

endpackage

/* common/hazardIf.sv */
`timescale 1ns/1ps

interface hazardIf import coreTypesPkg::*; ();

    logic [regAddrWidth-1:0] rs1D;
    logic [regAddrWidth-1:0] rs2D;
    logic [regAddrWidth-1:0] rs1E;
    logic [regAddrWidth-1:0] rs2E;
    logic [regAddrWidth-1:0] rdE;
    logic [regAddrWidth-1:0] rdM;
    logic [regAddrWidth-1:0] rdW;
    logic                    regWriteM;
    logic                    regWriteW;
    logic                    loadE;     // lw sitting in execute
    logic                    pcSrcE;    // redirect from execute

    logic                    stallF;
    logic                    stallD;
    logic                    flushD;
    logic                    flushE;
    logic [1:0]              forwardAE;
    logic [1:0]              forwardBE;

    modport dpPort (
        output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        output regWriteM, regWriteW, loadE, pcSrcE,
        input  stallF, stallD, flushD, flushE, forwardAE, forwardBE
    );

    modport hzPort (
        input  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        input  regWriteM, regWriteW, loadE, pcSrcE,
        output stallF, stallD, flushD, flushE, forwardAE, forwardBE
    );

endinterface

/* rtl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import coreTypesPkg::*;
(
    input  logic [6:0] instrOp,   // instr[6:0]
    input  logic [2:0] funct3,    // instr[14:12]
    input  logic       funct7b5,  // instr[30]
    output ctrlT       ctrlD,
    output immSrcT     immSrcD
);

    always_comb
    begin
        ctrlD   = '0;   // bubble unless decoded below
        immSrcD = immI;

        case (instrOp)
            opImm:
            begin
                case (funct3)
                    f3AddSub:   // addi
                    begin
                        ctrlD.regWrite   = 1'b1;
                        ctrlD.aluControl = aluAdd;
                        ctrlD.aluSrc     = 1'b1;
                    end
                    f3Sll:      // slli, funct7 must be zero
                    begin
                        if (!funct7b5)
                        begin
                            ctrlD.regWrite   = 1'b1;
                            ctrlD.aluControl = aluSll;
                            ctrlD.aluSrc     = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end

            opBranch:
            begin
                if (funct3 == f3Beq || funct3 == f3Bne)
                begin
                    ctrlD.branch     = 1'b1;
                    ctrlD.branchNe   = (funct3 == f3Bne);
                    ctrlD.aluControl = aluSub; // compare via zero flag
                    immSrcD          = immB;
                end
            end

            opStore:
            begin
                if (funct3 == f3Word)   // sw
                begin
                    ctrlD.memWrite   = 1'b1;
                    ctrlD.aluControl = aluAdd;
                    ctrlD.aluSrc     = 1'b1;
                    immSrcD          = immS;
                end
            end

            opLoad:
            begin
                if (funct3 == f3Word)   // lw
                begin
                    ctrlD.regWrite   = 1'b1;
                    ctrlD.resultSrc  = resMem;
                    ctrlD.aluControl = aluAdd;
                    ctrlD.aluSrc     = 1'b1;
                end
            end

            opJal:
            begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = resPc4;
                ctrlD.jump      = 1'b1;
                immSrcD         = immJ;
            end

            opJalr:
            begin
                if (funct3 == f3Jalr)
                begin
                    ctrlD.regWrite  = 1'b1;
                    ctrlD.resultSrc = resPc4;
                    ctrlD.jump      = 1'b1;
                    ctrlD.jalrSel   = 1'b1;
                end
            end

            default: ;  // unsupported opcode stays a bubble
        endcase
    end

endmodule

/* datapath/regFile.sv */
`timescale 1ns/1ps

module regFile import coreTypesPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [regAddrWidth-1:0] ra1,
    input  logic [regAddrWidth-1:0] ra2,
    output logic [dataWidth-1:0]    rd1,
    output logic [dataWidth-1:0]    rd2,
    input  logic                    we,
    input  logic [regAddrWidth-1:0] wa,
    input  logic [dataWidth-1:0]    wd
);

    logic [dataWidth-1:0] regs [32];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && wa != '0)    // x0 stays zero
            regs[wa] <= wd;
    end

    // write-first, decode sees the writeback value
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

/* datapath/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import coreTypesPkg::*;
(
    input  logic [dataWidth-1:0] srcA,
    input  logic [dataWidth-1:0] srcB,
    input  aluCtrlT              aluControl,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);

    always_comb
    begin
        case (aluControl)
            aluAdd:  result = srcA + srcB;
            aluSub:  result = srcA - srcB;      // also branch compare
            aluSll:  result = srcA << srcB[4:0];
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ps

module datapath import coreTypesPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [dataWidth-1:0]     instrF,
    output logic [imemAddrWidth-1:0] pcF,
    input  ctrlT                     ctrlD,
    input  immSrcT                   immSrcD,
    output logic [dataWidth-1:0]     instrD,
    hazardIf.dpPort                  hz,
    output logic                     dmemWe,
    output logic [addrWidth-1:0]     dmemAddr,
    output logic [dataWidth-1:0]     dmemWdata,
    input  logic [dataWidth-1:0]     dmemRdata
);

    logic [addrWidth-1:0]    pcFReg, pcPlus4F, pcNextF;
    logic [addrWidth-1:0]    pcD, pcPlus4D;
    logic [dataWidth-1:0]    immExtD, rd1D, rd2D;
    logic [regAddrWidth-1:0] rs1D, rs2D, rdD;
    ctrlT                    ctrlE, ctrlM;
    logic [dataWidth-1:0]    rd1E, rd2E, immExtE, srcAE, srcBE, writeDataE, aluResultE;
    logic [addrWidth-1:0]    pcE, pcPlus4E, targetE, jalrSumE;
    logic [regAddrWidth-1:0] rs1E, rs2E, rdE, rdM, rdW;
    logic                    zeroE, pcSrcE;
    logic [dataWidth-1:0]    aluResultM, writeDataM, aluResultW, readDataW, resultW;
    logic [addrWidth-1:0]    pcPlus4M, pcPlus4W;
    logic                    regWriteW;
    resultSrcT               resultSrcW;

    function automatic logic [dataWidth-1:0] fwdMux(
        input logic [1:0]           sel,
        input logic [dataWidth-1:0] regVal,
        input logic [dataWidth-1:0] memVal,
        input logic [dataWidth-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    // fetch
    assign pcPlus4F = pcFReg + 32'd4;
    assign pcNextF  = pcSrcE ? targetE : pcPlus4F;
    assign pcF      = pcFReg[imemAddrWidth+1:2];    // word index

    // decode
    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];
    assign rdD  = instrD[11:7];

    always_comb
    begin
        case (immSrcD)
            immI:    immExtD = {{20{instrD[31]}}, instrD[31:20]};
            immS:    immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                instrD[11:8], 1'b0};
            immJ:    immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                instrD[30:21], 1'b0};
            default: immExtD = '0;
        endcase
    end

    regFile rf0 (
        .clk  (clk),
        .rstN (rstN),
        .ra1  (rs1D),
        .ra2  (rs2D),
        .rd1  (rd1D),
        .rd2  (rd2D),
        .we   (regWriteW),
        .wa   (rdW),
        .wd   (resultW)
    );

    // execute
    assign srcAE      = fwdMux(hz.forwardAE, rd1E, aluResultM, resultW);
    assign writeDataE = fwdMux(hz.forwardBE, rd2E, aluResultM, resultW);
    assign srcBE      = ctrlE.aluSrc ? immExtE : writeDataE;

    aluUnit alu0 (
        .srcA       (srcAE),
        .srcB       (srcBE),
        .aluControl (ctrlE.aluControl),
        .result     (aluResultE),
        .zero       (zeroE)
    );

    assign jalrSumE = srcAE + immExtE;
    assign targetE  = ctrlE.jalrSel ? {jalrSumE[addrWidth-1:1], 1'b0} : pcE + immExtE;
    assign pcSrcE   = ctrlE.jump | (ctrlE.branch & (zeroE != ctrlE.branchNe));

    // memory stage drives the data bus directly
    assign dmemWe    = ctrlM.memWrite;
    assign dmemAddr  = aluResultM[addrWidth-1:0];
    assign dmemWdata = writeDataM;

    // writeback
    always_comb
    begin
        case (resultSrcW)
            resMem:  resultW = readDataW;
            resPc4:  resultW = pcPlus4W;
            default: resultW = aluResultW;
        endcase
    end

    // pc and pipeline control
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pcFReg     <= '0;
            instrD     <= '0;
            ctrlE      <= '0;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
            ctrlM      <= '0;
            rdM        <= '0;
            regWriteW  <= 1'b0;
            resultSrcW <= resAlu;
            rdW        <= '0;
        end
        else
        begin
            if (!hz.stallF)
                pcFReg <= pcNextF;
            if (hz.flushD)
                instrD <= '0;               // opcode 0 decodes as bubble
            else if (!hz.stallD)
                instrD <= instrF;
            if (hz.flushE)
            begin
                ctrlE <= '0;
                rs1E  <= '0;
                rs2E  <= '0;
                rdE   <= '0;
            end
            else
            begin
                ctrlE <= ctrlD;
                rs1E  <= rs1D;
                rs2E  <= rs2D;
                rdE   <= rdD;
            end
            ctrlM      <= ctrlE;
            rdM        <= rdE;
            regWriteW  <= ctrlM.regWrite;
            resultSrcW <= ctrlM.resultSrc;
            rdW        <= rdM;
        end
    end

    // data carried alongside
    always_ff @(posedge clk)
    begin
        if (!hz.stallD)
        begin
            pcD      <= pcFReg;
            pcPlus4D <= pcPlus4F;
        end
        rd1E       <= rd1D;
        rd2E       <= rd2D;
        immExtE    <= immExtD;
        pcE        <= pcD;
        pcPlus4E   <= pcPlus4D;
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        aluResultW <= aluResultM;
        readDataW  <= dmemRdata;
        pcPlus4W   <= pcPlus4M;
    end

    assign hz.rs1D      = rs1D;
    assign hz.rs2D      = rs2D;
    assign hz.rs1E      = rs1E;
    assign hz.rs2E      = rs2E;
    assign hz.rdE       = rdE;
    assign hz.rdM       = rdM;
    assign hz.rdW       = rdW;
    assign hz.regWriteM = ctrlM.regWrite;
    assign hz.regWriteW = regWriteW;
    assign hz.loadE     = (ctrlE.resultSrc == resMem);
    assign hz.pcSrcE    = pcSrcE;

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import coreTypesPkg::*;
(
    hazardIf.hzPort hz
);

    logic loadStall;

    // memory stage wins over writeback, it holds the newer value
    function automatic logic [1:0] fwdSel(
        input logic [regAddrWidth-1:0] rsE,
        input logic [regAddrWidth-1:0] rdM,
        input logic                    regWriteM,
        input logic [regAddrWidth-1:0] rdW,
        input logic                    regWriteW
    );
        if (rsE != '0 && rsE == rdM && regWriteM)
            return fwdMem;
        else if (rsE != '0 && rsE == rdW && regWriteW)
            return fwdWb;
        else
            return fwdReg;
    endfunction

    assign hz.forwardAE = fwdSel(hz.rs1E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
    assign hz.forwardBE = fwdSel(hz.rs2E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);

    // load result arrives too late for the next instruction
    assign loadStall = hz.loadE && (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

    assign hz.stallF = loadStall;
    assign hz.stallD = loadStall;
    assign hz.flushD = hz.pcSrcE;               // drop wrong-path fetch
    assign hz.flushE = loadStall | hz.pcSrcE;   // bubble into execute

endmodule

/* rtl/instrMem.sv */
`timescale 1ns/1ps

module instrMem import coreTypesPkg::*;
(
    input  logic                     clk,
    input  logic                     we,
    input  logic [imemAddrWidth-1:0] wAddr,
    input  logic [dataWidth-1:0]     wData,
    input  logic [imemAddrWidth-1:0] rAddr,
    output logic [dataWidth-1:0]     rData
);

    logic [dataWidth-1:0] mem [imemDepth];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[wAddr] <= wData;    // program load
    end

    assign rData = mem[rAddr];      // async read for fetch

endmodule

/* rtl/riscvCore.sv */
`timescale 1ns/1ps

module riscvCore import coreTypesPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     imemWe,
    input  logic [imemAddrWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0]     imemWdata,
    output logic                     dmemWe,
    output logic [addrWidth-1:0]     dmemAddr,
    output logic [dataWidth-1:0]     dmemWdata,
    input  logic [dataWidth-1:0]     dmemRdata
);

    logic [imemAddrWidth-1:0] pcF;
    logic [dataWidth-1:0]     instrF;
    logic [dataWidth-1:0]     instrD;
    ctrlT                     ctrlD;
    immSrcT                   immSrcD;

    hazardIf hzIf ();

    instrMem imem0 (
        .clk   (clk),
        .we    (imemWe),
        .wAddr (imemAddr),
        .wData (imemWdata),
        .rAddr (pcF),
        .rData (instrF)
    );

    controlUnit ctrl0 (
        .instrOp  (instrD[6:0]),
        .funct3   (instrD[14:12]),
        .funct7b5 (instrD[30]),
        .ctrlD    (ctrlD),
        .immSrcD  (immSrcD)
    );

    datapath dp0 (
        .clk       (clk),
        .rstN      (rstN),
        .instrF    (instrF),
        .pcF       (pcF),
        .ctrlD     (ctrlD),
        .immSrcD   (immSrcD),
        .instrD    (instrD),
        .hz        (hzIf.dpPort),
        .dmemWe    (dmemWe),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemRdata (dmemRdata)
    );

    hazardUnit hz0 (
        .hz (hzIf.hzPort)
    );

endmodule

/* dv/riscvCoreTb.sv */
`timescale 1ns/1ps

module riscvCoreTb import coreTypesPkg::*;
();

    logic                     clk;
    logic                     rstN;
    logic                     imemWe;
    logic [imemAddrWidth-1:0] imemAddr;
    logic [dataWidth-1:0]     imemWdata;
    logic                     dmemWe;
    logic [addrWidth-1:0]     dmemAddr;
    logic [dataWidth-1:0]     dmemWdata;
    logic [dataWidth-1:0]     dmemRdata;

    logic [dataWidth-1:0] dmem [64];        // data memory model
    logic [addrWidth-1:0] gotAddr [$];
    logic [dataWidth-1:0] gotData [$];

    string                testName [5];
    logic [dataWidth-1:0] prog     [5][10]; // slot 9 always holds the self loop
    logic [dataWidth-1:0] preset   [5][3];  // words at byte address 64, 68, 72
    logic [addrWidth-1:0] expAddr  [5][4];
    logic [dataWidth-1:0] expData  [5][4];
    int                   expCount [5];

    int errors;
    int passCount;
    int failCount;

    riscvCore dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .imemWe    (imemWe),
        .imemAddr  (imemAddr),
        .imemWdata (imemWdata),
        .dmemWe    (dmemWe),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemRdata (dmemRdata)
    );

    always #10 clk = ~clk;

    assign dmemRdata = dmem[dmemAddr[7:2]];    // same-cycle read

    always @(negedge clk)
    begin
        if (dmemWe && !rstN)
        begin
            $display("A store strobe showed up at time %0t while reset was low.", $time);
            errors++;
        end
        else if (dmemWe)
        begin
            gotAddr.push_back(dmemAddr);
            gotData.push_back(dmemWdata);
            dmem[dmemAddr[7:2]] = dmemWdata;
        end
    end

    // RV32I encodings
    function automatic logic [31:0] encI(input int imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input int imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input int imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input int imm);
        return encI(imm, rs1, f3AddSub, rd, opImm);
    endfunction

    function automatic logic [31:0] slli(input logic [4:0] rd, input logic [4:0] rs1,
                                         input int shamt);
        return encI(shamt & 31, rs1, f3Sll, rd, opImm);     // funct7 zero
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input int imm,
                                       input logic [4:0] rs1);
        return encI(imm, rs1, f3Word, rd, opLoad);
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input int imm,
                                       input logic [4:0] rs1);
        return encS(imm, rs2, rs1, f3Word);
    endfunction

    function automatic logic [31:0] jalr(input logic [4:0] rd, input int imm,
                                         input logic [4:0] rs1);
        return encI(imm, rs1, 3'b000, rd, opJalr);
    endfunction

    task automatic addStore(input int t, input logic [addrWidth-1:0] a,
                            input logic [dataWidth-1:0] d);
        expAddr[t][expCount[t]] = a;
        expData[t][expCount[t]] = d;
        expCount[t]++;
    endtask

    task automatic buildTable();
        logic [dataWidth-1:0] r [3];
        for (int t = 0; t < 5; t++)
        begin
            for (int k = 0; k < 10; k++)
                prog[t][k] = jal(0, 0);                 // self loop filler
            for (int k = 0; k < 3; k++)
                preset[t][k] = 32'hC0DE0000 | (t << 8) | k;
            expCount[t] = 0;
        end
        for (int k = 0; k < 3; k++)
            r[k] = $urandom();

        testName[0] = "arith";
        prog[0][0] = addi(1, 0, 5);
        prog[0][1] = addi(2, 1, 7);     // x1 from memory stage
        prog[0][2] = slli(3, 2, 3);
        prog[0][3] = slli(4, 2, 1);     // x2 from writeback
        prog[0][4] = sw(4, 0, 0);       // store data forwarded
        prog[0][5] = sw(3, 4, 0);
        prog[0][6] = sw(2, 8, 0);
        prog[0][7] = addi(5, 0, -3);
        prog[0][8] = sw(5, 12, 0);
        addStore(0, 0, 24);
        addStore(0, 4, 96);
        addStore(0, 8, 12);
        addStore(0, 12, 32'hFFFFFFFD);

        testName[1] = "loadUse";
        preset[1][0] = r[0];
        preset[1][1] = r[1];
        preset[1][2] = r[2];
        prog[1][0] = lw(1, 64, 0);
        prog[1][1] = addi(2, 1, 11);    // needs the stall
        prog[1][2] = sw(2, 0, 0);
        prog[1][3] = lw(3, 68, 0);
        prog[1][4] = sw(3, 4, 0);       // load feeds store data
        prog[1][5] = lw(4, 72, 0);
        prog[1][6] = addi(0, 0, 0);
        prog[1][7] = addi(5, 4, 1);
        prog[1][8] = sw(5, 8, 0);
        addStore(1, 0, r[0] + 11);
        addStore(1, 4, r[1]);
        addStore(1, 8, r[2] + 1);

        testName[2] = "branch";
        prog[2][0] = addi(1, 0, 3);
        prog[2][1] = encB(8, 0, 1, f3Beq);      // beq not taken
        prog[2][2] = sw(1, 0, 0);
        prog[2][3] = encB(8, 1, 1, f3Bne);      // bne not taken
        prog[2][4] = encB(8, 1, 1, f3Beq);      // beq taken
        prog[2][5] = sw(1, 4, 0);               // wrong path
        prog[2][6] = encB(8, 0, 1, f3Bne);      // bne taken
        prog[2][7] = sw(1, 8, 0);               // wrong path
        prog[2][8] = sw(1, 12, 0);
        addStore(2, 0, 3);
        addStore(2, 12, 3);

        testName[3] = "jump";
        prog[3][0] = jal(1, 12);
        prog[3][1] = sw(0, 0, 0);       // skipped
        prog[3][2] = sw(0, 4, 0);       // skipped
        prog[3][3] = sw(1, 8, 0);
        prog[3][4] = addi(2, 0, 27);
        prog[3][5] = jalr(3, 2, 2);     // 29 with bit 0 cleared is 28
        prog[3][6] = sw(0, 12, 0);      // skipped
        prog[3][7] = jal(4, 4);         // link shows the landing pc
        prog[3][8] = sw(4, 0, 3);       // address is the jalr link
        addStore(3, 8, 4);
        addStore(3, 24, 32);

        testName[4] = "resetX0";
        prog[4][0] = addi(0, 0, 9);
        prog[4][1] = sw(0, 0, 0);
        prog[4][2] = addi(1, 0, 5);
        prog[4][3] = 32'h000000B3;              // add x1,x0,x0 is not decoded
        prog[4][4] = sw(1, 4, 0);
        prog[4][5] = encS(8, 1, 0, 3'b000);     // sb, also a bubble
        prog[4][6] = sw(1, 12, 0);
        addStore(4, 0, 0);
        addStore(4, 4, 5);
        addStore(4, 12, 5);
    endtask

    task automatic checkStore(input int idx, input logic [addrWidth-1:0] gotA,
                              input logic [dataWidth-1:0] gotD,
                              input logic [addrWidth-1:0] expA,
                              input logic [dataWidth-1:0] expD);
        if (gotA !== expA || gotD !== expD)
        begin
            $display("CHECK FAILED at %0t: store %0d got [%h]=%h, expected [%h]=%h",
                     $time, idx, gotA, gotD, expA, expD);
            errors++;
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp)
        begin
            $display("CHECK FAILED at %0t: %s got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic runTest(input int t);
        int cycles;
        int errBefore;
        int n;
        errBefore = errors;
        @(negedge clk);
        rstN = 1'b0;
        gotAddr.delete();
        gotData.delete();
        for (int i = 0; i < 64; i++)
            dmem[i] = 32'hDA7A0000 | (i << 2);  // fill tracks the byte address
        for (int i = 0; i < 3; i++)
            dmem[16 + i] = preset[t][i];
        for (int i = 0; i < 10; i++)            // one word per reset cycle
        begin
            imemWe    = 1'b1;
            imemAddr  = i;
            imemWdata = prog[t][i];
            @(negedge clk);
        end
        imemWe = 1'b0;
        rstN   = 1'b1;

        cycles = 0;
        while (gotAddr.size() < expCount[t] && cycles < 200)
        begin
            @(posedge clk);
            cycles++;
        end
        if (gotAddr.size() < expCount[t])
        begin
            $display("Test %s timed out after 200 cycles waiting for its stores.",
                     testName[t]);
            errors++;
        end
        for (int i = 0; i < 30; i++)            // catch late stray stores
            @(posedge clk);

        checkCount(gotAddr.size(), expCount[t], "store count");
        n = (gotAddr.size() < expCount[t]) ? gotAddr.size() : expCount[t];
        for (int i = 0; i < n; i++)
            checkStore(i, gotAddr[i], gotData[i], expAddr[t][i], expData[t][i]);

        if (errors == errBefore)
        begin
            passCount++;
            $display("test %0d %s: passed", t, testName[t]);
        end
        else
        begin
            failCount++;
            $display("test %0d %s: failed", t, testName[t]);
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        rstN      = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemWdata = '0;
        errors    = 0;
        passCount = 0;
        failCount = 0;
        void'($urandom(3076));
        buildTable();
        for (int t = 0; t < 5; t++)
            runTest(t);
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (errors == 0 && failCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* riscvCore.f */
common/coreTypesPkg.sv
common/hazardIf.sv
rtl/controlUnit.sv
datapath/regFile.sv
datapath/aluUnit.sv
datapath/datapath.sv
rtl/hazardUnit.sv
rtl/instrMem.sv
rtl/riscvCore.sv
dv/riscvCoreTb.sv
